// File: run_sim.sh
#!/bin/sh
# Build and run the lane testbench with Verilator, pass or fail from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_gtp_link --Mdir obj_dir -o sim_gtp_link > build.log 2>&1 \
  && ./obj_dir/sim_gtp_link > sim.log 2>&1 \
  ; grep -q "ALL CHECKS PASSED" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: source/gtp_link_pkg.sv
// Lane package: link widths, flit and status structs, CRC-16 step function

`default_nettype none

package gtp_link_pkg;

  // =========================================================
  // Widths and sizes
  // =========================================================
  localparam int WORD_W = 16;
  localparam int NUM_VC = 3;
  localparam int CNT_W  = 8;

  // CCITT polynomial, no reflection, no final XOR
  localparam logic [WORD_W-1:0] CRC_INIT = 16'hFFFF;
  localparam logic [WORD_W-1:0] CRC_POLY = 16'h1021;

  typedef logic [1:0] vc_t;

  // =========================================================
  // Flit formats
  // =========================================================
  // vc only means something on the sop word
  typedef struct packed {
    logic              sop;
    logic              eop;
    vc_t               vc;
    logic [WORD_W-1:0] data;
  } flit_t;

  // crc_bad only means something on the eop word
  typedef struct packed {
    flit_t flit;
    logic  crc_bad;
  } rx_flit_t;

  // Sticky flags per VC, then wrapping packet counters
  typedef struct packed {
    logic [NUM_VC-1:0] crc_error;
    logic [NUM_VC-1:0] credit_error;
    logic [CNT_W-1:0]  tx_packets;
    logic [CNT_W-1:0]  rx_good;
    logic [CNT_W-1:0]  rx_bad;
  } link_status_t;

  // =========================================================
  // CRC-16 over one link word, MSB first
  // =========================================================
  function automatic logic [WORD_W-1:0] crc16_step(
    input logic [WORD_W-1:0] crc,
    input logic [WORD_W-1:0] data
  );
    logic [WORD_W-1:0] c;
    logic              fb;
    int                i;
    c = crc;
    for (i = WORD_W - 1; i >= 0; i--) begin
      fb = c[WORD_W-1] ^ data[i];
      c  = {c[WORD_W-2:0], 1'b0};
      if (fb) begin
        c = c ^ CRC_POLY;
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// File: source/gtp_link_top.sv
// Lane top: transmit framer, receive checker and status block

`default_nettype none
`timescale 1ns/1ps

module gtp_link_top #(
  parameter int CREDITS = 2
) (
  input  logic                        clk_gtp,
  input  logic                        i_arst_n,

  // Crossbar to link
  input  logic                        i_tx_valid,
  input  gtp_link_pkg::flit_t         i_tx_flit,
  output logic                        o_link_valid,
  output gtp_link_pkg::flit_t         o_link_flit,

  // Link to crossbar
  input  logic                        i_rx_valid,
  input  gtp_link_pkg::flit_t         i_rx_flit,
  output logic                        o_xbar_valid,
  output gtp_link_pkg::rx_flit_t      o_xbar_flit,
  input  logic                        i_credit_valid,
  input  gtp_link_pkg::vc_t           i_credit_vc,

  // Status
  input  logic                        i_clear_status,
  output gtp_link_pkg::link_status_t  o_status
);

  // =========================================================
  // Event wires toward the status block
  // =========================================================
  logic               pkt_sent;
  logic               pkt_done;
  gtp_link_pkg::vc_t  pkt_vc;
  logic               pkt_crc_bad;
  logic               credit_err;
  gtp_link_pkg::vc_t  credit_err_vc;

  link_tx_framer i0_link_tx_framer (
    .clk_gtp         ( clk_gtp ),
    .i_arst_n        ( i_arst_n ),
    .i_tx_valid      ( i_tx_valid ),
    .i_tx_flit       ( i_tx_flit ),
    .o_link_valid    ( o_link_valid ),
    .o_link_flit     ( o_link_flit ),
    .o_pkt_sent      ( pkt_sent )
  );

  link_rx_checker #(
    .CREDITS         ( CREDITS )
  ) i0_link_rx_checker (
    .clk_gtp         ( clk_gtp ),
    .i_arst_n        ( i_arst_n ),
    .i_rx_valid      ( i_rx_valid ),
    .i_rx_flit       ( i_rx_flit ),
    .i_credit_valid  ( i_credit_valid ),
    .i_credit_vc     ( i_credit_vc ),
    .o_xbar_valid    ( o_xbar_valid ),
    .o_xbar_flit     ( o_xbar_flit ),
    .o_pkt_done      ( pkt_done ),
    .o_pkt_vc        ( pkt_vc ),
    .o_pkt_crc_bad   ( pkt_crc_bad ),
    .o_credit_err    ( credit_err ),
    .o_credit_err_vc ( credit_err_vc )
  );

  link_status i0_link_status (
    .clk_gtp         ( clk_gtp ),
    .i_arst_n        ( i_arst_n ),
    .i_pkt_sent      ( pkt_sent ),
    .i_pkt_done      ( pkt_done ),
    .i_pkt_vc        ( pkt_vc ),
    .i_pkt_crc_bad   ( pkt_crc_bad ),
    .i_credit_err    ( credit_err ),
    .i_credit_err_vc ( credit_err_vc ),
    .i_clear_status  ( i_clear_status ),
    .o_status        ( o_status )
  );

endmodule

`default_nettype wire

// File: source/link_rx_checker.sv
// Receive checker: per-VC credits, one-word delivery buffer, CRC compare

`default_nettype none
`timescale 1ns/1ps

module link_rx_checker #(
  parameter int CREDITS = 2
) (
  input  logic                    clk_gtp,
  input  logic                    i_arst_n,

  // Link side
  input  logic                    i_rx_valid,
  input  gtp_link_pkg::flit_t     i_rx_flit,

  // Credit returns from the crossbar side
  input  logic                    i_credit_valid,
  input  gtp_link_pkg::vc_t       i_credit_vc,

  // Delivery to the crossbar side
  output logic                    o_xbar_valid,
  output gtp_link_pkg::rx_flit_t  o_xbar_flit,

  // Results toward the status block
  output logic                    o_pkt_done,
  output gtp_link_pkg::vc_t       o_pkt_vc,
  output logic                    o_pkt_crc_bad,
  output logic                    o_credit_err,
  output gtp_link_pkg::vc_t       o_credit_err_vc
);

  localparam int              CR_W   = $clog2(CREDITS + 1);
  localparam logic [CR_W-1:0] CR_MAX = CR_W'(CREDITS);

  // =========================================================
  // Signals
  // =========================================================
  logic [CR_W-1:0]                   credit [gtp_link_pkg::NUM_VC];
  logic [gtp_link_pkg::NUM_VC-1:0]   vc_take;
  logic [gtp_link_pkg::NUM_VC-1:0]   vc_ret;
  logic                              rx_sop;
  logic                              sop_ok;
  logic                              rx_body;
  logic                              in_pkt;
  logic                              dropping;
  gtp_link_pkg::flit_t               hold_flit;
  gtp_link_pkg::vc_t                 pkt_vc;
  logic [gtp_link_pkg::WORD_W-1:0]   crc_q;
  logic [gtp_link_pkg::WORD_W-1:0]   crc_next;
  logic                              crc_mismatch;

  assign rx_sop  = i_rx_valid && i_rx_flit.sop;
  assign sop_ok  = |vc_take;
  // Any later word of an accepted packet pushes out the held word
  assign rx_body = i_rx_valid && !i_rx_flit.sop && in_pkt && !dropping;

  // Held word is a data word once something follows it
  assign crc_next     = gtp_link_pkg::crc16_step(crc_q, hold_flit.data);
  assign crc_mismatch = (crc_next != i_rx_flit.data);

  // =========================================================
  // Credit counters
  // =========================================================
  for (genvar v = 0; v < gtp_link_pkg::NUM_VC; v++) begin : g_vc
    assign vc_take[v] = rx_sop && (i_rx_flit.vc == v) && (credit[v] != '0);
    assign vc_ret[v]  = i_credit_valid && (i_credit_vc == v);

    // Return and take on the same VC cancel out
    always_ff @(posedge clk_gtp or negedge i_arst_n) begin
      if (!i_arst_n) begin
        credit[v] <= CR_MAX;
      end else if (vc_take[v] && !vc_ret[v]) begin
        credit[v] <= credit[v] - 1'b1;
      end else if (vc_ret[v] && !vc_take[v] && (credit[v] != CR_MAX)) begin
        credit[v] <= credit[v] + 1'b1;
      end
    end

    a_credit_max: assert property (
      @(posedge clk_gtp) disable iff (!i_arst_n)
      credit[v] <= CR_MAX
    );
  end

  // =========================================================
  // Packet state and strobes
  // =========================================================
  always_ff @(posedge clk_gtp or negedge i_arst_n) begin
    if (!i_arst_n) begin
      in_pkt       <= 1'b0;
      dropping     <= 1'b0;
      o_xbar_valid <= 1'b0;
      o_pkt_done   <= 1'b0;
      o_credit_err <= 1'b0;
    end else begin
      o_xbar_valid <= rx_body;
      o_pkt_done   <= rx_body && i_rx_flit.eop;
      o_credit_err <= rx_sop && !sop_ok;
      if (rx_sop) begin
        in_pkt   <= !i_rx_flit.eop;
        // Refused packet is swallowed up to its eop
        dropping <= !sop_ok;
      end else if (i_rx_valid && i_rx_flit.eop) begin
        in_pkt   <= 1'b0;
        dropping <= 1'b0;
      end
    end
  end

  // =========================================================
  // Hold register and delivery
  // =========================================================
  always_ff @(posedge clk_gtp) begin
    if (rx_sop && sop_ok) begin
      hold_flit     <= i_rx_flit;
      hold_flit.eop <= 1'b0;
      crc_q         <= gtp_link_pkg::CRC_INIT;
      pkt_vc        <= i_rx_flit.vc;
    end else if (rx_body && !i_rx_flit.eop) begin
      hold_flit <= i_rx_flit;
      crc_q     <= crc_next;
    end

    if (rx_body) begin
      o_xbar_flit.flit     <= hold_flit;
      // Incoming CRC word closes the held word and is not delivered
      o_xbar_flit.flit.eop <= i_rx_flit.eop;
      o_xbar_flit.crc_bad  <= i_rx_flit.eop && crc_mismatch;
      o_pkt_vc             <= pkt_vc;
      o_pkt_crc_bad        <= crc_mismatch;
    end

    if (rx_sop) begin
      o_credit_err_vc <= i_rx_flit.vc;
    end
  end

endmodule

`default_nettype wire

// File: source/link_status.sv
// Lane status: sticky per-VC error flags and wrapping packet counters

`default_nettype none
`timescale 1ns/1ps

module link_status (
  input  logic                        clk_gtp,
  input  logic                        i_arst_n,

  // From the transmit framer
  input  logic                        i_pkt_sent,

  // From the receive checker
  input  logic                        i_pkt_done,
  input  gtp_link_pkg::vc_t           i_pkt_vc,
  input  logic                        i_pkt_crc_bad,
  input  logic                        i_credit_err,
  input  gtp_link_pkg::vc_t           i_credit_err_vc,

  input  logic                        i_clear_status,
  output gtp_link_pkg::link_status_t  o_status
);

  logic [gtp_link_pkg::NUM_VC-1:0] crc_set;
  logic [gtp_link_pkg::NUM_VC-1:0] credit_set;
  logic                            rx_good_inc;
  logic                            rx_bad_inc;

  assign rx_good_inc = i_pkt_done && !i_pkt_crc_bad;
  assign rx_bad_inc  = i_pkt_done && i_pkt_crc_bad;

  // Decode events to per-VC flag sets
  for (genvar v = 0; v < gtp_link_pkg::NUM_VC; v++) begin : g_vc
    assign crc_set[v]    = rx_bad_inc && (i_pkt_vc == v);
    assign credit_set[v] = i_credit_err && (i_credit_err_vc == v);
  end

  // =========================================================
  // Status register
  // =========================================================
  always_ff @(posedge clk_gtp or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_status <= '0;
    end else if (i_clear_status) begin
      // Clear beats any event in the same cycle
      o_status <= '0;
    end else begin
      o_status.crc_error    <= o_status.crc_error | crc_set;
      o_status.credit_error <= o_status.credit_error | credit_set;
      if (i_pkt_sent) begin
        o_status.tx_packets <= o_status.tx_packets + 1'b1;
      end
      if (rx_good_inc) begin
        o_status.rx_good <= o_status.rx_good + 1'b1;
      end
      if (rx_bad_inc) begin
        o_status.rx_bad <= o_status.rx_bad + 1'b1;
      end
    end
  end

  // VC numbers from the checker must name a real channel
  a_vc_range: assert property (
    @(posedge clk_gtp) disable iff (!i_arst_n)
    (i_pkt_done -> (i_pkt_vc < gtp_link_pkg::NUM_VC)) &&
    (i_credit_err -> (i_credit_err_vc < gtp_link_pkg::NUM_VC))
  );

endmodule

`default_nettype wire

// File: source/link_tx_framer.sv
// Transmit framer: registers flits toward the link and appends the CRC word

`default_nettype none
`timescale 1ns/1ps

module link_tx_framer (
  input  logic                 clk_gtp,
  input  logic                 i_arst_n,

  // Crossbar side
  input  logic                 i_tx_valid,
  input  gtp_link_pkg::flit_t  i_tx_flit,

  // Link side
  output logic                 o_link_valid,
  output gtp_link_pkg::flit_t  o_link_flit,

  // To status block, one pulse per packet
  output logic                 o_pkt_sent
);

  // =========================================================
  // Signals
  // =========================================================
  logic                              crc_pend;
  logic [gtp_link_pkg::WORD_W-1:0]   crc_q;
  logic [gtp_link_pkg::WORD_W-1:0]   crc_seed;
  logic [gtp_link_pkg::WORD_W-1:0]   crc_next;
  gtp_link_pkg::flit_t               data_flit;
  gtp_link_pkg::flit_t               crc_flit;

  // Sop restarts the running CRC
  assign crc_seed = i_tx_flit.sop ? gtp_link_pkg::CRC_INIT : crc_q;
  assign crc_next = gtp_link_pkg::crc16_step(crc_seed, i_tx_flit.data);

  // Data words go out without eop, only the CRC word closes the packet
  always_comb begin
    data_flit     = i_tx_flit;
    data_flit.eop = 1'b0;
  end

  assign crc_flit = '{sop: 1'b0, eop: 1'b1, vc: '0, data: crc_q};

  // =========================================================
  // Control
  // =========================================================
  always_ff @(posedge clk_gtp or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_link_valid <= 1'b0;
      o_pkt_sent   <= 1'b0;
      crc_pend     <= 1'b0;
    end else begin
      o_link_valid <= i_tx_valid || crc_pend;
      o_pkt_sent   <= crc_pend;
      // CRC word is due the cycle after the eop data word
      crc_pend     <= i_tx_valid && i_tx_flit.eop;
    end
  end

  // =========================================================
  // Datapath
  // =========================================================
  always_ff @(posedge clk_gtp) begin
    if (crc_pend) begin
      o_link_flit <= crc_flit;
    end else if (i_tx_valid) begin
      o_link_flit <= data_flit;
      crc_q       <= crc_next;
    end
  end

  // Sender must leave the CRC slot free after every eop
  a_idle_after_eop: assert property (
    @(posedge clk_gtp) disable iff (!i_arst_n)
    i_tx_valid && i_tx_flit.eop |=> !i_tx_valid
  );

endmodule

`default_nettype wire

// File: tb.f
source/gtp_link_pkg.sv
source/link_tx_framer.sv
source/link_rx_checker.sv
source/link_status.sv
source/gtp_link_top.sv
tests/tb_clock_gen.sv
tests/tb_gtp_link.sv

// File: tests/tb_clock_gen.sv
// Testbench clock and reset generator: 20 ns clock, reset held low for 8 cycles

`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 10,
  parameter int RESET_CYCLES   = 8
) (
  output logic clk_gtp,
  output logic o_arst_n
);

  initial begin
    clk_gtp = 1'b0;
    forever #(HALF_PERIOD_NS) clk_gtp = ~clk_gtp;
  end

  // Release reset on a rising edge
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_gtp);
    o_arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_gtp_link.sv
// Lane testbench: stimulus table, reference model, compare tasks and checks

`default_nettype none
`timescale 1ns/1ps

module tb_gtp_link;

  localparam int CREDITS     = 2;
  localparam int WAIT_CYCLES = 40;
  localparam int NUM_ROWS    = 25;

  typedef enum logic [1:0] {OP_TX, OP_RX, OP_CREDIT, OP_CLEAR} op_e;

  typedef struct packed {
    op_e               op;
    gtp_link_pkg::vc_t vc;
    logic [2:0]        len;
    logic              corrupt;
  } row_t;

  // =========================================================
  // Stimulus table
  // =========================================================
  localparam row_t ROWS [NUM_ROWS] = '{
    '{OP_TX, 2'd0, 3'd1, 1'b0}, '{OP_TX, 2'd1, 3'd2, 1'b0}, '{OP_TX, 2'd2, 3'd3, 1'b0},
    '{OP_TX, 2'd0, 3'd4, 1'b0}, '{OP_TX, 2'd1, 3'd5, 1'b0}, '{OP_TX, 2'd2, 3'd5, 1'b0},
    '{OP_RX, 2'd0, 3'd3, 1'b0}, '{OP_RX, 2'd1, 3'd1, 1'b0}, '{OP_RX, 2'd2, 3'd2, 1'b1},
    // VC 0 runs dry on its third packet
    '{OP_CREDIT, 2'd0, 3'd0, 1'b0}, '{OP_RX, 2'd0, 3'd2, 1'b0}, '{OP_RX, 2'd0, 3'd4, 1'b0},
    '{OP_RX, 2'd0, 3'd3, 1'b0}, '{OP_CREDIT, 2'd0, 3'd0, 1'b0}, '{OP_CREDIT, 2'd0, 3'd0, 1'b0},
    '{OP_RX, 2'd0, 3'd2, 1'b0},
    // Second return on VC 1 saturates
    '{OP_CREDIT, 2'd1, 3'd0, 1'b0}, '{OP_CREDIT, 2'd1, 3'd0, 1'b0}, '{OP_RX, 2'd1, 3'd2, 1'b0},
    '{OP_RX, 2'd1, 3'd1, 1'b0}, '{OP_RX, 2'd1, 3'd1, 1'b0},
    '{OP_CLEAR, 2'd0, 3'd0, 1'b0}, '{OP_TX, 2'd1, 3'd2, 1'b0}, '{OP_RX, 2'd0, 3'd1, 1'b0},
    '{OP_RX, 2'd2, 3'd3, 1'b1}
  };

  logic                        clk_gtp;
  logic                        arst_n;
  logic                        tx_valid;
  gtp_link_pkg::flit_t         tx_flit;
  logic                        link_valid;
  gtp_link_pkg::flit_t         link_flit;
  logic                        rx_valid;
  gtp_link_pkg::flit_t         rx_flit;
  logic                        xbar_valid;
  gtp_link_pkg::rx_flit_t      xbar_flit;
  logic                        credit_valid;
  gtp_link_pkg::vc_t           credit_vc;
  logic                        clear_status;
  gtp_link_pkg::link_status_t  status;

  // Reference model state and captured outputs
  gtp_link_pkg::link_status_t      exp_status;
  int                              credits [gtp_link_pkg::NUM_VC];
  logic [15:0]                     lfsr;
  int                              cyc = 0;
  gtp_link_pkg::flit_t             link_q [$];
  int                              link_cyc [$];
  gtp_link_pkg::rx_flit_t          xbar_q [$];

  tb_clock_gen i0_tb_clock_gen (
    .clk_gtp  ( clk_gtp ),
    .o_arst_n ( arst_n )
  );

  gtp_link_top #(
    .CREDITS        ( CREDITS )
  ) uut (
    .clk_gtp        ( clk_gtp ),
    .i_arst_n       ( arst_n ),
    .i_tx_valid     ( tx_valid ),
    .i_tx_flit      ( tx_flit ),
    .o_link_valid   ( link_valid ),
    .o_link_flit    ( link_flit ),
    .i_rx_valid     ( rx_valid ),
    .i_rx_flit      ( rx_flit ),
    .o_xbar_valid   ( xbar_valid ),
    .o_xbar_flit    ( xbar_flit ),
    .i_credit_valid ( credit_valid ),
    .i_credit_vc    ( credit_vc ),
    .i_clear_status ( clear_status ),
    .o_status       ( status )
  );

  always @(posedge clk_gtp) begin
    cyc <= cyc + 1;
  end

  // Outputs are captured mid-cycle
  always @(negedge clk_gtp) begin
    if (link_valid) begin
      link_q.push_back(link_flit);
      link_cyc.push_back(cyc);
    end
    if (xbar_valid) begin
      xbar_q.push_back(xbar_flit);
    end
  end

  // =========================================================
  // Error handling and compare tasks
  // =========================================================
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // vc is only defined on the sop word
  task automatic check_flit(input string name, input gtp_link_pkg::flit_t got,
                            input gtp_link_pkg::flit_t exp);
    gtp_link_pkg::flit_t g;
    gtp_link_pkg::flit_t e;
    g = got;
    e = exp;
    if (!exp.sop) begin
      g.vc = '0;
      e.vc = '0;
    end
    if (g !== e) begin
      stop_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  // crc_bad is compared on the eop word only
  task automatic check_rx_flit(input string name, input gtp_link_pkg::rx_flit_t got,
                               input gtp_link_pkg::rx_flit_t exp);
    gtp_link_pkg::flit_t g;
    gtp_link_pkg::flit_t e;
    g = got.flit;
    e = exp.flit;
    if (!exp.flit.sop) begin
      g.vc = '0;
      e.vc = '0;
    end
    if (g !== e || (exp.flit.eop && got.crc_bad !== exp.crc_bad)) begin
      stop_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_status(input string name, input gtp_link_pkg::link_status_t got,
                              input gtp_link_pkg::link_status_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  // =========================================================
  // Waits, each bounded
  // =========================================================
  task automatic wait_reset_release();
    int t;
    for (t = 0; t < WAIT_CYCLES && arst_n !== 1'b1; t++) begin
      @(posedge clk_gtp);
    end
    if (arst_n !== 1'b1) begin
      stop_run("reset was never released");
    end
  endtask

  task automatic wait_link(input int n);
    int t;
    for (t = 0; t < WAIT_CYCLES && link_q.size() < n; t++) begin
      @(posedge clk_gtp);
    end
    if (link_q.size() < n) begin
      stop_run("timeout waiting for words on the link output");
    end
  endtask

  task automatic wait_xbar(input int n);
    int t;
    for (t = 0; t < WAIT_CYCLES && xbar_q.size() < n; t++) begin
      @(posedge clk_gtp);
    end
    if (xbar_q.size() < n) begin
      stop_run("timeout waiting for words on the crossbar output");
    end
  endtask

  // Poll until the status settles, then compare
  task automatic wait_status();
    int t;
    for (t = 0; t < WAIT_CYCLES; t++) begin
      @(negedge clk_gtp);
      if (status === exp_status) begin
        break;
      end
    end
    check_status("o_status", status, exp_status);
  endtask

  // =========================================================
  // Stimulus
  // =========================================================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_word(output logic [gtp_link_pkg::WORD_W-1:0] w);
    int b;
    w = '0;
    for (b = 0; b < gtp_link_pkg::WORD_W; b++) begin
      lfsr = lfsr_step(lfsr);
      w    = {w[gtp_link_pkg::WORD_W-2:0], lfsr[0]};
    end
  endtask

  task automatic run_tx(input gtp_link_pkg::vc_t vc, input int len);
    gtp_link_pkg::flit_t             f;
    gtp_link_pkg::flit_t             exp_q [$];
    logic [gtp_link_pkg::WORD_W-1:0] w;
    logic [gtp_link_pkg::WORD_W-1:0] crc;
    int                              i;
    crc = gtp_link_pkg::CRC_INIT;
    for (i = 0; i < len; i++) begin
      next_word(w);
      f = '{sop: (i == 0), eop: (i == len - 1), vc: vc, data: w};
      @(posedge clk_gtp);
      tx_valid <= 1'b1;
      tx_flit  <= f;
      f.eop = 1'b0;
      exp_q.push_back(f);
      crc = gtp_link_pkg::crc16_step(crc, w);
    end
    @(posedge clk_gtp);
    tx_valid <= 1'b0;
    tx_flit  <= '0;
    f = '{sop: 1'b0, eop: 1'b1, vc: 2'd0, data: crc};
    exp_q.push_back(f);
    wait_link(len + 1);
    for (i = 0; i <= len; i++) begin
      check_flit("o_link_flit", link_q[i], exp_q[i]);
      if (i > 0 && link_cyc[i] != link_cyc[i - 1] + 1) begin
        stop_run("link words of one packet are not on consecutive cycles");
      end
    end
    link_q.delete();
    link_cyc.delete();
    exp_status.tx_packets = exp_status.tx_packets + 1'b1;
  endtask

  task automatic drive_rx(input gtp_link_pkg::flit_t f);
    @(posedge clk_gtp);
    rx_valid <= 1'b1;
    rx_flit  <= f;
  endtask

  task automatic run_rx(input gtp_link_pkg::vc_t vc, input int len, input logic corrupt);
    gtp_link_pkg::flit_t             f;
    gtp_link_pkg::rx_flit_t          e;
    gtp_link_pkg::rx_flit_t          exp_q [$];
    logic [gtp_link_pkg::WORD_W-1:0] w;
    logic [gtp_link_pkg::WORD_W-1:0] crc;
    logic                            accept;
    int                              i;
    accept = (credits[vc] > 0);
    crc    = gtp_link_pkg::CRC_INIT;
    for (i = 0; i < len; i++) begin
      next_word(w);
      f = '{sop: (i == 0), eop: 1'b0, vc: vc, data: w};
      drive_rx(f);
      crc        = gtp_link_pkg::crc16_step(crc, w);
      e.flit     = f;
      e.flit.eop = (i == len - 1);
      e.crc_bad  = corrupt && (i == len - 1);
      exp_q.push_back(e);
    end
    // Trailing CRC word, inverted for a corrupted packet
    f = '{sop: 1'b0, eop: 1'b1, vc: vc, data: corrupt ? ~crc : crc};
    drive_rx(f);
    @(posedge clk_gtp);
    rx_valid <= 1'b0;
    rx_flit  <= '0;
    if (accept) begin
      credits[vc] = credits[vc] - 1;
      wait_xbar(len);
      for (i = 0; i < len; i++) begin
        check_rx_flit("o_xbar_flit", xbar_q[i], exp_q[i]);
      end
      xbar_q.delete();
      if (corrupt) begin
        exp_status.rx_bad        = exp_status.rx_bad + 1'b1;
        exp_status.crc_error[vc] = 1'b1;
      end else begin
        exp_status.rx_good = exp_status.rx_good + 1'b1;
      end
    end else begin
      exp_status.credit_error[vc] = 1'b1;
    end
  endtask

  task automatic run_credit(input gtp_link_pkg::vc_t vc);
    @(posedge clk_gtp);
    credit_valid <= 1'b1;
    credit_vc    <= vc;
    @(posedge clk_gtp);
    credit_valid <= 1'b0;
    if (credits[vc] < CREDITS) begin
      credits[vc] = credits[vc] + 1;
    end
  endtask

  task automatic run_clear();
    @(posedge clk_gtp);
    clear_status <= 1'b1;
    @(posedge clk_gtp);
    clear_status <= 1'b0;
    exp_status = '0;
  endtask

  task automatic expect_quiet();
    if (link_q.size() != 0 || xbar_q.size() != 0) begin
      stop_run($sformatf("unexpected output words: %0d on the link, %0d on the crossbar",
                         link_q.size(), xbar_q.size()));
    end
  endtask

  // =========================================================
  // Main sequence
  // =========================================================
  initial begin
    int r;
    int v;
    tx_valid     = 1'b0;
    tx_flit      = '0;
    rx_valid     = 1'b0;
    rx_flit      = '0;
    credit_valid = 1'b0;
    credit_vc    = '0;
    clear_status = 1'b0;
    lfsr         = 16'd57596;
    exp_status   = '0;
    for (v = 0; v < gtp_link_pkg::NUM_VC; v++) begin
      credits[v] = CREDITS;
    end
    wait_reset_release();
    wait_status();
    for (r = 0; r < NUM_ROWS; r++) begin
      expect_quiet();
      case (ROWS[r].op)
        OP_TX:     run_tx(ROWS[r].vc, int'(ROWS[r].len));
        OP_RX:     run_rx(ROWS[r].vc, int'(ROWS[r].len), ROWS[r].corrupt);
        OP_CREDIT: run_credit(ROWS[r].vc);
        default:   run_clear();
      endcase
      wait_status();
    end
    expect_quiet();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
